// ==== ipu.f ====
design/ipu_pkg.sv
design/ipu_multiplier.sv
design/ipu_serdiv.sv
design/ipu_dspu.sv
design/ipu_result_arbiter.sv
design/ipu.sv
tests/ipu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the IPU testbench with Verilator, run it and scan the log for failures
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ipu_tb -f ipu.f -o ipu_sim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/ipu_sim > sim.log 2>&1 || echo "Simulator returned a nonzero status"
grep -q "TB FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0

// ==== tests/ipu_tb.sv ====
// IPU testbench with stimulus table, response scoreboard, random back-pressure and watchdog
`timescale 1ns/10ps

module ipu_tb;

  localparam int unsigned IdWidth    = 5;
  localparam int unsigned NumEntries = 32;   // One id per entry
  localparam int          ClkPeriod  = 20;
  localparam int          DriveDelay = 2;

  // funct7 groups of the R-type encodings
  localparam logic [6:0] F7MulDiv = 7'b0000001;
  localparam logic [6:0] F7Alu    = 7'b0000010;  // slet, min, max
  localparam logic [6:0] F7Abs    = 7'b0000101;
  localparam logic [6:0] F7Ext    = 7'b0001000;
  localparam logic [6:0] F7Clip   = 7'b0001010;

  typedef struct packed {
    ipu_pkg::ipu_req_t req;
    ipu_pkg::ipu_rsp_t exp;   // Expected response
  } entry_t;

  logic               clk_i, rst_n_i;
  ipu_pkg::ipu_req_t  req_i;
  logic [IdWidth-1:0] qid_i, pid_o;
  logic               qvalid_i, qready_o;
  ipu_pkg::ipu_rsp_t  rsp_o;
  logic               pvalid_o, pready_i;

  entry_t      table_q [NumEntries];
  int unsigned num_added;
  logic        issued  [NumEntries];  // Request offered
  int unsigned seen    [NumEntries];  // Responses per id
  int unsigned num_answered;

  ipu #(.IdWidth(IdWidth), .DspEnable(1'b1)) DUT (
    .clk_i, .rst_n_i, .req_i, .qid_i, .qvalid_i, .qready_o,
    .rsp_o, .pid_o, .pvalid_o, .pready_i
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] encode_r(logic [6:0] funct7, logic [4:0] rs2,
                                           logic [2:0] funct3);
    return {funct7, rs2, 5'd10, funct3, 5'd11, 7'b0110011};  // rs1 x10, rd x11
  endfunction

  function automatic logic [31:0] next_random(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_rsp(string name, ipu_pkg::ipu_rsp_t act, ipu_pkg::ipu_rsp_t exp);
    if (act !== exp) begin
      $display("[FAIL] %s: data=%h error=%h, expected data=%h error=%h",
               name, act.data, act.error, exp.data, exp.error);
      stop_on_error("Response value mismatch");
    end
  endtask

  task automatic check_id(string name, logic [IdWidth-1:0] act, logic [IdWidth-1:0] exp);
    if (act !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, act, exp);
      stop_on_error("Response id mismatch");
    end
  endtask

  task automatic add_entry(logic [31:0] instr, logic [31:0] a, logic [31:0] b,
                           logic [31:0] data, logic err);
    table_q[num_added].req = '{instr: instr, op_a: a, op_b: b};
    table_q[num_added].exp = '{data: data, error: err};
    num_added++;
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic build_table();
    num_added = 0;
    // EngMul, corner operands
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b001), 32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 0);
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b010), 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b011), 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 0);
    // EngDiv, ordinary then zero divisor and overflow
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b100), 32'hFFFF_FFEC, 32'd3, 32'hFFFF_FFFA, 0);
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b110), 32'hFFFF_FFEC, 32'd3, 32'hFFFF_FFFE, 0);
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b101), 32'hFFFF_FFEC, 32'd3, 32'h5555_554E, 0);
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b100), 32'd100, 32'd0, 32'hFFFF_FFFF, 0);
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b111), 32'd100, 32'd0, 32'd100, 0);
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b100), 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 0);
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b110), 32'h8000_0000, 32'hFFFF_FFFF, 32'd0, 0);
    // All-zero word, then a multiply behind it
    add_entry(32'h0000_0000, 32'd1, 32'd2, 32'd0, 1);
    add_entry(encode_r(F7MulDiv, 5'd2, 3'b000), 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 0);
    // EngDsp while the last divide is still running
    add_entry(encode_r(F7Abs, 5'd0, 3'b000), 32'hFFFF_FFFB, 32'd0, 32'd5, 0);
    add_entry(encode_r(F7Abs, 5'd0, 3'b000), 32'h8000_0000, 32'd0, 32'h8000_0000, 0);
    add_entry(encode_r(F7Alu, 5'd2, 3'b010), 32'hFFFF_FFFF, 32'd1, 32'd1, 0);
    add_entry(encode_r(F7Alu, 5'd2, 3'b011), 32'hFFFF_FFFF, 32'd1, 32'd0, 0);
    add_entry(encode_r(F7Alu, 5'd2, 3'b100), 32'hFFFF_FFFF, 32'd1, 32'hFFFF_FFFF, 0);
    add_entry(encode_r(F7Alu, 5'd2, 3'b101), 32'hFFFF_FFFF, 32'd1, 32'd1, 0);
    add_entry(encode_r(F7Alu, 5'd2, 3'b110), 32'h8000_0000, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 0);
    add_entry(encode_r(F7Alu, 5'd2, 3'b111), 32'h8000_0000, 32'h7FFF_FFFF, 32'h8000_0000, 0);
    add_entry(encode_r(F7Ext, 5'd0, 3'b100), 32'h1234_8765, 32'd0, 32'hFFFF_8765, 0);
    add_entry(encode_r(F7Ext, 5'd0, 3'b101), 32'h1234_8765, 32'd0, 32'h0000_8765, 0);
    add_entry(encode_r(F7Ext, 5'd0, 3'b110), 32'h1234_5680, 32'd0, 32'hFFFF_FF80, 0);
    add_entry(encode_r(F7Ext, 5'd0, 3'b111), 32'h1234_5680, 32'd0, 32'h0000_0080, 0);
    // CSR opcode is illegal here
    add_entry(32'h3401_1073, 32'd7, 32'd8, 32'd0, 1);
    // Clips, immediate in the rs2 field
    add_entry(encode_r(F7Clip, 5'd1, 3'b001), 32'd5, 32'd0, 32'd0, 0);
    add_entry(encode_r(F7Clip, 5'd8, 3'b001), 32'hFFFF_FF00, 32'd0, 32'hFFFF_FF80, 0);
    add_entry(encode_r(F7Clip, 5'd31, 3'b001), 32'h7FFF_FFFF, 32'd0, 32'h3FFF_FFFF, 0);
    add_entry(encode_r(F7Clip, 5'd8, 3'b010), 32'hFFFF_FFF9, 32'd0, 32'd0, 0);
    add_entry(encode_r(F7Clip, 5'd3, 3'b101), 32'd100, 32'd50, 32'd50, 0);
    add_entry(encode_r(F7Clip, 5'd3, 3'b101), 32'hFFFF_FF9C, 32'hFFFF_FFFB, 32'd4, 0);
    add_entry(encode_r(F7Clip, 5'd3, 3'b110), 32'd30, 32'd50, 32'd30, 0);
  endtask

  // ----------------------------------------
  // Clock, back-pressure, watchdog
  // ----------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : backpressure
    logic [31:0] rnd;
    rnd      = 32'd36519;  // Seed
    pready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #DriveDelay;
      rnd      = next_random(rnd);
      pready_i = |rnd[1:0];  // Ready about three cycles in four
    end
  end

  initial begin
    #(ClkPeriod * (NumEntries * 60 + 8));
    stop_on_error("Timeout, responses did not arrive in time");
  end

  // ----------------------------------------
  // Response scoreboard
  // ----------------------------------------
  task automatic record_response(logic [IdWidth-1:0] id, ipu_pkg::ipu_rsp_t rsp);
    if (!issued[id]) begin
      stop_on_error($sformatf("Response with id %0d came before its request", id));
    end else if (seen[id] != 0) begin
      stop_on_error($sformatf("Id %0d was answered more than once", id));
    end else begin
      check_rsp($sformatf("rsp_o of id %0d", id), rsp, table_q[id].exp);
      seen[id]++;
      num_answered++;
    end
  endtask

  initial begin : monitor
    logic               held;      // Response stalled last cycle
    logic [IdWidth-1:0] held_id;
    ipu_pkg::ipu_rsp_t  held_rsp;
    held = 1'b0;
    forever begin
      @(negedge clk_i);            // Stable point between edges
      if (rst_n_i) begin
        if (held) begin
          if (!pvalid_o) stop_on_error("Stalled response was dropped while pready_i was low");
          check_id("pid_o", pid_o, held_id);
          check_rsp("rsp_o", rsp_o, held_rsp);
        end
        held     = pvalid_o & ~pready_i;
        held_id  = pid_o;
        held_rsp = rsp_o;
        if (pvalid_o && pready_i) record_response(pid_o, rsp_o);  // Transfer at next edge
      end
    end
  end

  // ----------------------------------------
  // Request driver
  // ----------------------------------------
  initial begin : stimulus
    int unsigned missing;
    rst_n_i      = 1'b0;
    req_i        = '0;
    qid_i        = '0;
    qvalid_i     = 1'b0;
    num_answered = 0;
    for (int i = 0; i < NumEntries; i++) begin
      issued[i] = 1'b0;
      seen[i]   = 0;
    end
    build_table();
    repeat (8) @(posedge clk_i);
    #DriveDelay;
    rst_n_i = 1'b1;
    for (int i = 0; i < NumEntries; i++) begin
      @(posedge clk_i);
      #DriveDelay;
      req_i     = table_q[i].req;
      qid_i     = IdWidth'(i);
      qvalid_i  = 1'b1;
      issued[i] = 1'b1;
      do @(negedge clk_i); while (!qready_o);  // Held until accepted
    end
    @(posedge clk_i);
    #DriveDelay;
    qvalid_i = 1'b0;
    wait (num_answered == NumEntries);
    repeat (20) @(posedge clk_i);  // Room for stray duplicates
    missing = 0;
    for (int i = 0; i < NumEntries; i++) begin
      if (seen[i] != 1) missing++;
    end
    if (missing == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d ids were not answered exactly once", missing));
    end
  end

endmodule

// ==== design/ipu.sv ====
// Integer processing unit top with dispatch decoder, illegal responder and engines
`timescale 1ns/10ps

module ipu #(
  parameter int unsigned IdWidth   = 5,
  parameter bit          DspEnable = 1'b1
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  ipu_pkg::ipu_req_t  req_i,
  input  logic [IdWidth-1:0] qid_i,
  input  logic               qvalid_i,
  output logic               qready_o,
  output ipu_pkg::ipu_rsp_t  rsp_o,
  output logic [IdWidth-1:0] pid_o,
  output logic               pvalid_o,
  input  logic               pready_i
);
  localparam int unsigned NumInp = DspEnable ? 4 : 3;
  localparam int unsigned ErrIdx = DspEnable ? ipu_pkg::EngErr : ipu_pkg::EngDsp;

  logic mul_valid_op, mul_ready_op;   // Request side per engine
  logic div_valid_op, div_ready_op;
  logic dsp_valid_op, dsp_ready_op;
  logic err_valid_op;
  logic [ipu_pkg::DataWidth-1:0] mul_res, div_res;
  logic               err_valid_q;    // Illegal responder
  logic [IdWidth-1:0] err_id_q;
  ipu_pkg::ipu_rsp_t [NumInp-1:0]    arb_rsp;
  logic [NumInp-1:0][IdWidth-1:0]    arb_id;
  logic [NumInp-1:0]                 arb_valid, arb_ready;

  // ----------------------------------------
  // Dispatch decoder
  // ----------------------------------------
  always_comb begin
    mul_valid_op = 1'b0;
    div_valid_op = 1'b0;
    dsp_valid_op = 1'b0;
    err_valid_op = 1'b0;
    qready_o     = 1'b0;
    unique casez (req_i.instr)
      ipu_pkg::INSTR_MUL, ipu_pkg::INSTR_MULH,
      ipu_pkg::INSTR_MULHSU, ipu_pkg::INSTR_MULHU: begin
        mul_valid_op = qvalid_i;
        qready_o     = mul_ready_op;
      end
      ipu_pkg::INSTR_DIV, ipu_pkg::INSTR_DIVU,
      ipu_pkg::INSTR_REM, ipu_pkg::INSTR_REMU: begin
        div_valid_op = qvalid_i;
        qready_o     = div_ready_op;
      end
      ipu_pkg::INSTR_P_ABS, ipu_pkg::INSTR_P_SLET, ipu_pkg::INSTR_P_SLETU,
      ipu_pkg::INSTR_P_MIN, ipu_pkg::INSTR_P_MINU, ipu_pkg::INSTR_P_MAX,
      ipu_pkg::INSTR_P_MAXU, ipu_pkg::INSTR_P_EXTHS, ipu_pkg::INSTR_P_EXTHZ,
      ipu_pkg::INSTR_P_EXTBS, ipu_pkg::INSTR_P_EXTBZ, ipu_pkg::INSTR_P_CLIP,
      ipu_pkg::INSTR_P_CLIPU, ipu_pkg::INSTR_P_CLIPR, ipu_pkg::INSTR_P_CLIPUR: begin
        if (DspEnable) begin
          dsp_valid_op = qvalid_i;
          qready_o     = dsp_ready_op;
        end else begin
          err_valid_op = qvalid_i;  // No DSP unit, answer as illegal
          qready_o     = ~err_valid_q;
        end
      end
      default: begin
        err_valid_op = qvalid_i;
        qready_o     = ~err_valid_q;  // Accept when responder empty
      end
    endcase
  end

  // ----------------------------------------
  // Illegal instruction responder
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) err_valid_q <= 1'b0;
    else if (err_valid_op && !err_valid_q) err_valid_q <= 1'b1;
    else if (arb_ready[ErrIdx]) err_valid_q <= 1'b0;  // Taken by arbiter
  end

  always_ff @(posedge clk_i) begin
    if (err_valid_op && !err_valid_q) err_id_q <= qid_i;
  end

  assign arb_rsp[ErrIdx]   = '{data: '0, error: 1'b1};
  assign arb_id[ErrIdx]    = err_id_q;
  assign arb_valid[ErrIdx] = err_valid_q;

  // ----------------------------------------
  // Engines
  // ----------------------------------------
  ipu_multiplier #(.IdWidth(IdWidth)) i_mul (
    .clk_i, .rst_n_i, .req_i, .id_i(qid_i),
    .valid_i(mul_valid_op), .ready_o(mul_ready_op),
    .res_o(mul_res), .id_o(arb_id[ipu_pkg::EngMul]),
    .valid_o(arb_valid[ipu_pkg::EngMul]), .ready_i(arb_ready[ipu_pkg::EngMul])
  );
  assign arb_rsp[ipu_pkg::EngMul] = '{data: mul_res, error: 1'b0};

  ipu_serdiv #(.IdWidth(IdWidth)) i_div (
    .clk_i, .rst_n_i, .req_i, .id_i(qid_i),
    .valid_i(div_valid_op), .ready_o(div_ready_op),
    .res_o(div_res), .id_o(arb_id[ipu_pkg::EngDiv]),
    .valid_o(arb_valid[ipu_pkg::EngDiv]), .ready_i(arb_ready[ipu_pkg::EngDiv])
  );
  assign arb_rsp[ipu_pkg::EngDiv] = '{data: div_res, error: 1'b0};

  if (DspEnable) begin : gen_dspu
    logic [ipu_pkg::DataWidth-1:0] dsp_res;
    ipu_dspu #(.IdWidth(IdWidth)) i_dspu (
      .req_i, .id_i(qid_i), .valid_i(dsp_valid_op), .ready_o(dsp_ready_op),
      .res_o(dsp_res), .id_o(arb_id[ipu_pkg::EngDsp]),
      .valid_o(arb_valid[ipu_pkg::EngDsp]), .ready_i(arb_ready[ipu_pkg::EngDsp])
    );
    assign arb_rsp[ipu_pkg::EngDsp] = '{data: dsp_res, error: 1'b0};
  end else begin : gen_no_dspu
    assign dsp_ready_op = 1'b0;  // Never selected
  end

  ipu_result_arbiter #(.NumInp(NumInp), .IdWidth(IdWidth)) i_arb (
    .clk_i, .rst_n_i, .rsp_i(arb_rsp), .id_i(arb_id),
    .valid_i(arb_valid), .ready_o(arb_ready),
    .rsp_o, .id_o(pid_o), .valid_o(pvalid_o), .ready_i(pready_i)
  );

endmodule

// ==== design/ipu_result_arbiter.sv ====
// Round-robin stream arbiter for engine responses and ids with a grant lock
`timescale 1ns/10ps

module ipu_result_arbiter #(
  parameter int unsigned NumInp  = 4,
  parameter int unsigned IdWidth = 5
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  ipu_pkg::ipu_rsp_t [NumInp-1:0] rsp_i,
  input  logic [NumInp-1:0][IdWidth-1:0] id_i,
  input  logic [NumInp-1:0]              valid_i,
  output logic [NumInp-1:0]              ready_o,
  output ipu_pkg::ipu_rsp_t              rsp_o,
  output logic [IdWidth-1:0]             id_o,
  output logic                           valid_o,
  input  logic                           ready_i
);
  localparam int unsigned IdxW  = $clog2(NumInp);
  localparam int unsigned BeatW = IdWidth + $bits(ipu_pkg::ipu_rsp_t);

  logic [NumInp-1:0][BeatW-1:0] beat;  // Id and response per input
  logic [IdxW-1:0]              ptr_q, gnt_q, sel, gnt;
  logic                         lock_q, found;

  for (genvar i = 0; i < NumInp; i++) begin : gen_beat
    assign beat[i] = {id_i[i], rsp_i[i]};
  end

  // First valid input at or after the pointer
  always_comb begin
    int unsigned idx;
    sel   = ptr_q;
    found = 1'b0;
    for (int unsigned i = 0; i < NumInp; i++) begin
      idx = ptr_q + i;
      if (idx >= NumInp) idx = idx - NumInp;  // Wrap
      if (!found && valid_i[idx]) begin
        sel   = IdxW'(idx);
        found = 1'b1;
      end
    end
  end

  assign gnt            = lock_q ? gnt_q : sel;  // Hold grant while stalled
  assign valid_o        = valid_i[gnt];
  assign {id_o, rsp_o}  = beat[gnt];

  always_comb begin
    ready_o      = '0;
    ready_o[gnt] = ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q  <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= valid_o & ~ready_i;
      gnt_q  <= gnt;
      if (valid_o && ready_i) ptr_q <= (gnt == IdxW'(NumInp - 1)) ? '0 : gnt + 1'b1;
    end
  end

  // Stalled output keeps its beat
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(id_o) && $stable(rsp_o));

endmodule

// ==== design/ipu_dspu.sv ====
// Combinational Xpulpimg DSP unit with shared comparator and clip bound logic
`timescale 1ns/10ps

module ipu_dspu #(
  parameter int unsigned IdWidth = 5
) (
  input  ipu_pkg::ipu_req_t             req_i,
  input  logic [IdWidth-1:0]            id_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  output logic [ipu_pkg::DataWidth-1:0] res_o,
  output logic [IdWidth-1:0]            id_o,
  output logic                          valid_o,
  input  logic                          ready_i
);
  localparam int unsigned W = ipu_pkg::DataWidth;

  // Zero-cycle handshake
  assign valid_o = valid_i;
  assign ready_o = ready_i;
  assign id_o    = id_i;

  logic [W-1:0] op_a, op_b;
  logic [4:0]   ximm;             // Clip immediate
  logic         cmp_signed;
  logic         clip_unsigned;    // Lower bound is zero
  logic         clip_register;    // Bounds from rs2
  enum logic [1:0] {OpbReg, OpbZero, OpbClip} opb_sel;
  enum logic [3:0] {
    ResAbs, ResSle, ResMin, ResMax, ResExths, ResExthz, ResExtbs, ResExtbz, ResClip
  } res_sel;

  assign op_a = req_i.op_a;
  assign op_b = req_i.op_b;
  assign ximm = req_i.instr[24:20];

  // ----------------------------------------
  // Decoder
  // ----------------------------------------
  always_comb begin
    cmp_signed    = 1'b1;
    clip_unsigned = 1'b0;
    clip_register = 1'b0;
    opb_sel       = OpbReg;
    res_sel       = ResAbs;
    unique casez (req_i.instr)
      ipu_pkg::INSTR_P_ABS:    opb_sel = OpbZero;  // a <= 0 selects negation
      ipu_pkg::INSTR_P_SLET:   res_sel = ResSle;
      ipu_pkg::INSTR_P_SLETU: begin
        cmp_signed = 1'b0;
        res_sel    = ResSle;
      end
      ipu_pkg::INSTR_P_MIN:    res_sel = ResMin;
      ipu_pkg::INSTR_P_MINU: begin
        cmp_signed = 1'b0;
        res_sel    = ResMin;
      end
      ipu_pkg::INSTR_P_MAX:    res_sel = ResMax;
      ipu_pkg::INSTR_P_MAXU: begin
        cmp_signed = 1'b0;
        res_sel    = ResMax;
      end
      ipu_pkg::INSTR_P_EXTHS:  res_sel = ResExths;
      ipu_pkg::INSTR_P_EXTHZ:  res_sel = ResExthz;
      ipu_pkg::INSTR_P_EXTBS:  res_sel = ResExtbs;
      ipu_pkg::INSTR_P_EXTBZ:  res_sel = ResExtbz;
      ipu_pkg::INSTR_P_CLIP,
      ipu_pkg::INSTR_P_CLIPU,
      ipu_pkg::INSTR_P_CLIPR,
      ipu_pkg::INSTR_P_CLIPUR: begin
        opb_sel       = OpbClip;
        res_sel       = ResClip;
        clip_unsigned = req_i.instr[13];  // funct3 010 and 110
        clip_register = req_i.instr[14];  // funct3 101 and 110
      end
      default: ;
    endcase
  end

  // ----------------------------------------
  // Clip bounds
  // ----------------------------------------
  logic [W:0]   ones_shl;
  logic [W-1:0] imm_lo;             // -2^(imm-1)
  logic [W-1:0] clip_lo, clip_hi;   // Lower and upper bound
  logic         use_lo;             // rs1 or upper bound negative
  logic [W-1:0] cmp_a, cmp_b;
  logic         cmp_le;

  assign ones_shl = {(W+1){1'b1}} << ximm;
  assign imm_lo   = ones_shl[W:1];
  assign clip_lo  = clip_unsigned ? '0 : (clip_register ? ~op_b : imm_lo);
  assign clip_hi  = clip_register ? op_b : ~imm_lo;
  // One compare suffices once the bound is picked by the signs
  assign use_lo   = op_a[W-1] | clip_hi[W-1];

  // Shared comparator, sign bit extended when signed
  assign cmp_a = op_a;
  always_comb begin
    unique case (opb_sel)
      OpbReg:  cmp_b = op_b;
      OpbZero: cmp_b = '0;
      OpbClip: cmp_b = use_lo ? clip_lo : clip_hi;
      default: cmp_b = '0;
    endcase
  end
  assign cmp_le = $signed({cmp_signed & cmp_a[W-1], cmp_a})
               <= $signed({cmp_signed & cmp_b[W-1], cmp_b});

  // ----------------------------------------
  // Result mux
  // ----------------------------------------
  always_comb begin
    unique case (res_sel)
      ResAbs:   res_o = cmp_le ? -op_a : op_a;
      ResSle:   res_o = {{(W-1){1'b0}}, cmp_le};
      ResMin:   res_o = cmp_le ? op_a : op_b;
      ResMax:   res_o = cmp_le ? op_b : op_a;
      ResExths: res_o = {{(W-16){op_a[15]}}, op_a[15:0]};
      ResExthz: res_o = {{(W-16){1'b0}}, op_a[15:0]};
      ResExtbs: res_o = {{(W-8){op_a[7]}}, op_a[7:0]};
      ResExtbz: res_o = {{(W-8){1'b0}}, op_a[7:0]};
      // Below lower bound saturates low, negative rs1 above it passes, else saturate high
      ResClip:  res_o = cmp_le ? (use_lo ? clip_lo : op_a) : (op_a[W-1] ? op_a : clip_hi);
      default:  res_o = '0;
    endcase
  end

endmodule

// ==== design/ipu_serdiv.sv ====
// Radix-2 restoring serial divider with RISC-V divide-by-zero and overflow results
`timescale 1ns/10ps

module ipu_serdiv #(
  parameter int unsigned IdWidth = 5
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  ipu_pkg::ipu_req_t             req_i,
  input  logic [IdWidth-1:0]            id_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  output logic [ipu_pkg::DataWidth-1:0] res_o,
  output logic [IdWidth-1:0]            id_o,
  output logic                          valid_o,
  input  logic                          ready_i
);
  localparam int unsigned W    = ipu_pkg::DataWidth;
  localparam int unsigned CntW = $clog2(W + 1);

  enum logic [1:0] {Idle, Divide, Done} state_q;

  logic [2:0]         funct3;
  logic               is_signed, neg_a, neg_b;
  logic               accept, fix_step;
  logic [CntW-1:0]    cnt_q;           // Iteration count, W marks fix-up
  logic [W-1:0]       quo_q, rem_q;    // Shifting quotient and partial remainder
  logic [W-1:0]       dvs_q, dvd_q;    // Divisor magnitude, raw dividend
  logic               zero_q;          // Divisor was zero
  logic               neg_quo_q, neg_rem_q;
  logic               rem_sel_q;       // REM or REMU
  logic [IdWidth-1:0] id_q;
  logic [W-1:0]       res_q;
  logic [W:0]         trial;           // Shift and subtract
  logic [W-1:0]       quo_fix, rem_fix;

  assign funct3    = req_i.instr[14:12];
  assign is_signed = ~funct3[0];  // DIV, REM
  assign neg_a     = is_signed & req_i.op_a[W-1];
  assign neg_b     = is_signed & req_i.op_b[W-1];

  assign ready_o  = state_q == Idle;
  assign valid_o  = state_q == Done;
  assign accept   = valid_i & ready_o;
  assign fix_step = cnt_q == CntW'(W);

  assign trial   = {rem_q, quo_q[W-1]} - {1'b0, dvs_q};
  assign quo_fix = neg_quo_q ? -quo_q : quo_q;
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        Idle: begin
          cnt_q <= '0;
          if (accept) state_q <= Divide;  // Load cycle
        end
        Divide: begin
          cnt_q <= cnt_q + 1'b1;
          if (fix_step) state_q <= Done;
        end
        Done: if (ready_i) state_q <= Idle;  // Held until taken
        default: state_q <= Idle;
      endcase
    end
  end

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      quo_q     <= neg_a ? -req_i.op_a : req_i.op_a;  // Dividend magnitude
      rem_q     <= '0;
      dvs_q     <= neg_b ? -req_i.op_b : req_i.op_b;
      dvd_q     <= req_i.op_a;
      zero_q    <= req_i.op_b == '0;
      neg_quo_q <= neg_a ^ neg_b;
      neg_rem_q <= neg_a;               // Remainder follows the dividend
      rem_sel_q <= funct3[1];
      id_q      <= id_i;
    end else if (state_q == Divide && !fix_step) begin
      rem_q <= trial[W] ? {rem_q[W-2:0], quo_q[W-1]} : trial[W-1:0];
      quo_q <= {quo_q[W-2:0], ~trial[W]};
    end else if (state_q == Divide) begin
      // Most negative over -1 falls out of the magnitudes: quotient wraps to the dividend
      if (zero_q) res_q <= rem_sel_q ? dvd_q : '1;
      else        res_q <= rem_sel_q ? rem_fix : quo_fix;
    end
  end

  assign res_o = res_q;
  assign id_o  = id_q;

  // Result only after all iterations and the fix-up
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(valid_o) |-> cnt_q == CntW'(W + 1));

endmodule

// ==== design/ipu_multiplier.sv ====
// Two-stage pipelined 32x32 multiplier with low or high word select
`timescale 1ns/10ps

module ipu_multiplier #(
  parameter int unsigned IdWidth = 5
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  ipu_pkg::ipu_req_t             req_i,
  input  logic [IdWidth-1:0]            id_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  output logic [ipu_pkg::DataWidth-1:0] res_o,
  output logic [IdWidth-1:0]            id_o,
  output logic                          valid_o,
  input  logic                          ready_i
);
  localparam int unsigned W = ipu_pkg::DataWidth;

  logic [2:0]          funct3;
  logic                sign_a, sign_b;  // Operand treated as signed
  logic                s1_en, s2_en;    // Stage load enables
  // Stage 1, sign extended operands
  logic                s1_valid_q;
  logic signed [W:0]   s1_a_q, s1_b_q;
  logic                s1_hi_q;
  logic [IdWidth-1:0]  s1_id_q;
  // Stage 2, full product
  logic                s2_valid_q;
  logic [2*W-1:0]      s2_prod_q;
  logic                s2_hi_q;
  logic [IdWidth-1:0]  s2_id_q;
  logic signed [2*W+1:0] prod;

  assign funct3 = req_i.instr[14:12];
  assign sign_a = ~(funct3[1] & funct3[0]);  // Only MULHU has unsigned rs1
  assign sign_b = ~funct3[1];                // MUL and MULH

  assign s2_en   = s1_valid_q & (~s2_valid_q | ready_i);  // Stage 2 free or draining
  assign ready_o = ~s1_valid_q | s2_en;
  assign s1_en   = valid_i & ready_o;
  assign prod    = s1_a_q * s1_b_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= s1_en | (s1_valid_q & ~s2_en);
      s2_valid_q <= s2_en | (s2_valid_q & ~ready_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_en) begin
      s1_a_q  <= {sign_a & req_i.op_a[W-1], req_i.op_a};
      s1_b_q  <= {sign_b & req_i.op_b[W-1], req_i.op_b};
      s1_hi_q <= funct3 != 3'b000;  // Any MULH form
      s1_id_q <= id_i;
    end
    if (s2_en) begin
      s2_prod_q <= prod[2*W-1:0];
      s2_hi_q   <= s1_hi_q;
      s2_id_q   <= s1_id_q;
    end
  end

  assign valid_o = s2_valid_q;
  assign res_o   = s2_hi_q ? s2_prod_q[2*W-1:W] : s2_prod_q[W-1:0];
  assign id_o    = s2_id_q;

  // Output held while stalled
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(res_o) && $stable(id_o));

endmodule

// ==== design/ipu_pkg.sv ====
// Data width, instruction match patterns, request and response structs, engine index
package ipu_pkg;

  localparam int unsigned DataWidth = 32;  // Operand and result width

  // ----------------------------------------
  // RV32M patterns
  // ----------------------------------------
  localparam logic [31:0] INSTR_MUL    = 32'b0000001??????????000?????0110011;
  localparam logic [31:0] INSTR_MULH   = 32'b0000001??????????001?????0110011;
  localparam logic [31:0] INSTR_MULHSU = 32'b0000001??????????010?????0110011;
  localparam logic [31:0] INSTR_MULHU  = 32'b0000001??????????011?????0110011;
  localparam logic [31:0] INSTR_DIV    = 32'b0000001??????????100?????0110011;
  localparam logic [31:0] INSTR_DIVU   = 32'b0000001??????????101?????0110011;
  localparam logic [31:0] INSTR_REM    = 32'b0000001??????????110?????0110011;
  localparam logic [31:0] INSTR_REMU   = 32'b0000001??????????111?????0110011;

  // ----------------------------------------
  // Xpulpimg scalar patterns
  // ----------------------------------------
  localparam logic [31:0] INSTR_P_ABS    = 32'b000010100000?????000?????0110011;  // rs2 is zero
  localparam logic [31:0] INSTR_P_SLET   = 32'b0000010??????????010?????0110011;
  localparam logic [31:0] INSTR_P_SLETU  = 32'b0000010??????????011?????0110011;
  localparam logic [31:0] INSTR_P_MIN    = 32'b0000010??????????100?????0110011;
  localparam logic [31:0] INSTR_P_MINU   = 32'b0000010??????????101?????0110011;
  localparam logic [31:0] INSTR_P_MAX    = 32'b0000010??????????110?????0110011;
  localparam logic [31:0] INSTR_P_MAXU   = 32'b0000010??????????111?????0110011;
  localparam logic [31:0] INSTR_P_EXTHS  = 32'b000100000000?????100?????0110011;
  localparam logic [31:0] INSTR_P_EXTHZ  = 32'b000100000000?????101?????0110011;
  localparam logic [31:0] INSTR_P_EXTBS  = 32'b000100000000?????110?????0110011;
  localparam logic [31:0] INSTR_P_EXTBZ  = 32'b000100000000?????111?????0110011;
  // Clip immediate sits in the rs2 field, bits 24:20
  localparam logic [31:0] INSTR_P_CLIP   = 32'b0001010??????????001?????0110011;
  localparam logic [31:0] INSTR_P_CLIPU  = 32'b0001010??????????010?????0110011;
  localparam logic [31:0] INSTR_P_CLIPR  = 32'b0001010??????????101?????0110011;
  localparam logic [31:0] INSTR_P_CLIPUR = 32'b0001010??????????110?????0110011;

  // ----------------------------------------
  // Request and response
  // ----------------------------------------
  typedef struct packed {
    logic [31:0]          instr;  // Raw instruction word
    logic [DataWidth-1:0] op_a;   // rs1 value
    logic [DataWidth-1:0] op_b;   // rs2 value
  } ipu_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;   // Result
    logic                 error;  // Illegal instruction
  } ipu_rsp_t;

  // Arbiter input index
  typedef enum logic [1:0] {
    EngMul = 2'd0,
    EngDiv = 2'd1,
    EngDsp = 2'd2,
    EngErr = 2'd3
  } engine_e;

endpackage
